/* hdl/soc_bus_pkg.sv */
package soc_bus_pkg;

  // ##########################################################################
  // bus widths
  // ##########################################################################

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 64;
  localparam int STRB_W     = DATA_W / 8;
  localparam int HALF_W     = DATA_W / 2;       // upper-half access for 32-bit software
  localparam int BYTE_OFF_W = $clog2(STRB_W);   // byte offset bits inside one word

  // ##########################################################################
  // address map
  // ##########################################################################

  localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
  localparam int SRAM_WORDS = 512;                      // 64-bit words
  localparam int SRAM_AW    = $clog2(SRAM_WORDS);
  localparam logic [ADDR_W-1:0] SRAM_SIZE = ADDR_W'(SRAM_WORDS * STRB_W);

  localparam logic [ADDR_W-1:0] CLINT_BASE       = 32'h0200_0000;
  localparam logic [ADDR_W-1:0] MTIMECMP_ADDR    = CLINT_BASE + 32'h0000_4000;
  localparam logic [ADDR_W-1:0] MTIMECMP_HI_ADDR = CLINT_BASE + 32'h0000_4004;
  localparam logic [ADDR_W-1:0] MTIME_ADDR       = CLINT_BASE + 32'h0000_bff8;
  localparam logic [ADDR_W-1:0] MTIME_HI_ADDR    = CLINT_BASE + 32'h0000_bffc;

  // ##########################################################################
  // types
  // ##########################################################################

  typedef enum logic [1:0] {
    ZONE_SRAM  = 2'd0,
    ZONE_CLINT = 2'd1,
    ZONE_NONE  = 2'd2    // unmapped, answered by the crossbar
  } zone_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_e;

endpackage

/* hdl/axi_lite_if.sv */
interface axi_lite_if;
  import soc_bus_pkg::*;

  // read address
  logic              arvalid;
  logic              arready;
  logic [ADDR_W-1:0] araddr;

  // read data
  logic              rvalid;
  logic              rready;
  logic [DATA_W-1:0] rdata;
  resp_e             rresp;

  // write address
  logic              awvalid;
  logic              awready;
  logic [ADDR_W-1:0] awaddr;

  // write data
  logic              wvalid;
  logic              wready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;

  // write response
  logic              bvalid;
  logic              bready;
  resp_e             bresp;

  modport master (
    output arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
    input  arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
  );

  modport slave (
    input  arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wstrb, bready,
    output arready, rvalid, rdata, rresp, awready, wready, bvalid, bresp
  );

endinterface

/* hdl/soc_xbar.sv */
module soc_xbar (
  input  logic       clk,
  input  logic       rst,
  axi_lite_if.slave  m,
  axi_lite_if.master sram_bus,
  axi_lite_if.master clint_bus,
  output logic       device_access
);
  import soc_bus_pkg::*;

  zone_e ar_zone;   // decode of the live read address
  zone_e aw_zone;   // decode of the live write address
  zone_e rd_zone;   // read target held until r transfer
  zone_e wr_zone;   // write target held until b transfer
  logic  rd_busy;
  logic  wr_busy;
  logic  ar_fire;
  logic  r_fire;
  logic  aw_fire;
  logic  b_fire;

  function automatic zone_e decode_zone(input logic [ADDR_W-1:0] addr);
    zone_e zone;
    if (addr >= SRAM_BASE && addr < SRAM_BASE + SRAM_SIZE)
      zone = ZONE_SRAM;
    else if (addr == MTIME_ADDR || addr == MTIME_HI_ADDR ||
             addr == MTIMECMP_ADDR || addr == MTIMECMP_HI_ADDR)
      zone = ZONE_CLINT;
    else
      zone = ZONE_NONE;
    return zone;
  endfunction

  assign ar_zone = decode_zone(m.araddr);
  assign aw_zone = decode_zone(m.awaddr);

  // any non-sram request on either address channel
  assign device_access = (m.arvalid && ar_zone != ZONE_SRAM) ||
                         (m.awvalid && aw_zone != ZONE_SRAM);

  // ##########################################################################
  // read path
  // ##########################################################################

  assign sram_bus.araddr   = m.araddr;
  assign clint_bus.araddr  = m.araddr;
  assign sram_bus.arvalid  = m.arvalid && !rd_busy && ar_zone == ZONE_SRAM;
  assign clint_bus.arvalid = m.arvalid && !rd_busy && ar_zone == ZONE_CLINT;
  assign sram_bus.rready   = m.rready && rd_busy && rd_zone == ZONE_SRAM;
  assign clint_bus.rready  = m.rready && rd_busy && rd_zone == ZONE_CLINT;

  always_comb begin
    m.arready = 1'b0;
    if (!rd_busy) begin
      case (ar_zone)
        ZONE_SRAM:  m.arready = sram_bus.arready;
        ZONE_CLINT: m.arready = clint_bus.arready;
        default:    m.arready = m.arvalid;   // decode error taken locally
      endcase
    end
  end

  always_comb begin
    m.rvalid = 1'b0;
    m.rdata  = '0;
    m.rresp  = RESP_OKAY;
    if (rd_busy) begin
      case (rd_zone)
        ZONE_SRAM: begin
          m.rvalid = sram_bus.rvalid;
          m.rdata  = sram_bus.rdata;
          m.rresp  = sram_bus.rresp;
        end
        ZONE_CLINT: begin
          m.rvalid = clint_bus.rvalid;
          m.rdata  = clint_bus.rdata;
          m.rresp  = clint_bus.rresp;
        end
        default: begin
          m.rvalid = 1'b1;   // one cycle after ar, data stays zero
          m.rresp  = RESP_DECERR;
        end
      endcase
    end
  end

  assign ar_fire = m.arvalid && m.arready;
  assign r_fire  = m.rvalid && m.rready;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_busy <= 1'b0;
      rd_zone <= ZONE_NONE;
    end else if (ar_fire) begin
      rd_busy <= 1'b1;
      rd_zone <= ar_zone;
    end else if (r_fire) begin
      rd_busy <= 1'b0;
    end
  end

  // ##########################################################################
  // write path
  // ##########################################################################

  assign sram_bus.awaddr   = m.awaddr;
  assign sram_bus.wdata    = m.wdata;
  assign sram_bus.wstrb    = m.wstrb;
  assign clint_bus.awaddr  = m.awaddr;
  assign clint_bus.wdata   = m.wdata;
  assign clint_bus.wstrb   = m.wstrb;
  assign sram_bus.awvalid  = m.awvalid && !wr_busy && aw_zone == ZONE_SRAM;
  assign sram_bus.wvalid   = m.wvalid && !wr_busy && aw_zone == ZONE_SRAM;
  assign clint_bus.awvalid = m.awvalid && !wr_busy && aw_zone == ZONE_CLINT;
  assign clint_bus.wvalid  = m.wvalid && !wr_busy && aw_zone == ZONE_CLINT;
  assign sram_bus.bready   = m.bready && wr_busy && wr_zone == ZONE_SRAM;
  assign clint_bus.bready  = m.bready && wr_busy && wr_zone == ZONE_CLINT;

  always_comb begin
    m.awready = 1'b0;
    if (!wr_busy) begin
      case (aw_zone)
        ZONE_SRAM:  m.awready = sram_bus.awready;
        ZONE_CLINT: m.awready = clint_bus.awready;
        default:    m.awready = m.awvalid && m.wvalid;
      endcase
    end
  end

  assign m.wready = m.awready;   // aw and w always move together

  always_comb begin
    case (wr_zone)
      ZONE_SRAM: begin
        m.bvalid = wr_busy && sram_bus.bvalid;
        m.bresp  = sram_bus.bresp;
      end
      ZONE_CLINT: begin
        m.bvalid = wr_busy && clint_bus.bvalid;
        m.bresp  = clint_bus.bresp;
      end
      default: begin
        m.bvalid = wr_busy;
        m.bresp  = RESP_DECERR;
      end
    endcase
  end

  assign aw_fire = m.awvalid && m.awready;
  assign b_fire  = m.bvalid && m.bready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_busy <= 1'b0;
      wr_zone <= ZONE_NONE;
    end else if (aw_fire) begin
      wr_busy <= 1'b1;
      wr_zone <= aw_zone;
    end else if (b_fire) begin
      wr_busy <= 1'b0;
    end
  end

endmodule

/* hdl/sram_slave.sv */
module sram_slave (
  input  logic      clk,
  input  logic      rst,
  axi_lite_if.slave s
);
  import soc_bus_pkg::*;

  logic [DATA_W-1:0]  mem [SRAM_WORDS];
  logic [ADDR_W-1:0]  rd_off;    // byte offset from the sram base
  logic [ADDR_W-1:0]  wr_off;
  logic [SRAM_AW-1:0] rd_idx;
  logic [SRAM_AW-1:0] wr_idx;
  logic [DATA_W-1:0]  rdata_q;
  logic               r_pend;    // read response held
  logic               b_pend;    // write response held
  logic               rd_en;
  logic               wr_en;

  assign rd_off = s.araddr - SRAM_BASE;
  assign wr_off = s.awaddr - SRAM_BASE;
  assign rd_idx = rd_off[BYTE_OFF_W +: SRAM_AW];
  assign wr_idx = wr_off[BYTE_OFF_W +: SRAM_AW];

  // ##########################################################################
  // handshakes
  // ##########################################################################

  assign s.arready = s.arvalid && !r_pend;
  assign s.awready = s.awvalid && s.wvalid && !b_pend;
  assign s.wready  = s.awready;

  assign rd_en = s.arvalid && s.arready;
  assign wr_en = s.awvalid && s.awready;

  assign s.rvalid = r_pend;
  assign s.rdata  = rdata_q;
  assign s.rresp  = RESP_OKAY;
  assign s.bvalid = b_pend;
  assign s.bresp  = RESP_OKAY;

  always_ff @(posedge clk) begin
    if (rst) begin
      r_pend <= 1'b0;
    end else if (rd_en) begin
      r_pend <= 1'b1;
    end else if (s.rready) begin
      r_pend <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      b_pend <= 1'b0;
    end else if (wr_en) begin
      b_pend <= 1'b1;
    end else if (s.bready) begin
      b_pend <= 1'b0;
    end
  end

  // ##########################################################################
  // storage
  // ##########################################################################

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata_q <= mem[rd_idx];   // sampled at the ar transfer
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (s.wstrb[i]) begin
          mem[wr_idx][i*8 +: 8] <= s.wdata[i*8 +: 8];
        end
      end
    end
  end

endmodule

/* hdl/clint_timer.sv */
module clint_timer (
  input  logic      clk,
  input  logic      rst,
  axi_lite_if.slave s,
  output logic      timer_irq
);
  import soc_bus_pkg::*;

  logic [DATA_W-1:0] mtime;
  logic [DATA_W-1:0] mtimecmp;
  logic [DATA_W-1:0] mtime_nxt;
  logic [DATA_W-1:0] mtimecmp_nxt;
  logic [DATA_W-1:0] rd_word;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] wr_hi_data;   // low-lane data moved to the upper half
  logic [STRB_W-1:0] wr_hi_strb;
  logic              r_pend;
  logic              b_pend;
  logic              rd_en;
  logic              wr_en;

  function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i])
        res[i*8 +: 8] = new_word[i*8 +: 8];
    end
    return res;
  endfunction

  assign s.arready = s.arvalid && !r_pend;
  assign s.awready = s.awvalid && s.wvalid && !b_pend;
  assign s.wready  = s.awready;
  assign rd_en     = s.arvalid && s.arready;
  assign wr_en     = s.awvalid && s.awready;

  assign s.rvalid = r_pend;
  assign s.rdata  = rdata_q;
  assign s.rresp  = RESP_OKAY;
  assign s.bvalid = b_pend;
  assign s.bresp  = RESP_OKAY;

  // ##########################################################################
  // register access
  // ##########################################################################

  always_comb begin
    case (s.araddr)
      MTIME_ADDR:       rd_word = mtime;
      MTIME_HI_ADDR:    rd_word = {{HALF_W{1'b0}}, mtime[DATA_W-1:HALF_W]};
      MTIMECMP_ADDR:    rd_word = mtimecmp;
      MTIMECMP_HI_ADDR: rd_word = {{HALF_W{1'b0}}, mtimecmp[DATA_W-1:HALF_W]};
      default:          rd_word = '0;
    endcase
  end

  assign wr_hi_data = {s.wdata[HALF_W-1:0], {HALF_W{1'b0}}};
  assign wr_hi_strb = {s.wstrb[STRB_W/2-1:0], {(STRB_W/2){1'b0}}};

  always_comb begin
    mtime_nxt    = mtime + 1'b1;   // free running unless written
    mtimecmp_nxt = mtimecmp;
    if (wr_en) begin
      case (s.awaddr)
        MTIME_ADDR:       mtime_nxt    = merge_bytes(mtime, s.wdata, s.wstrb);
        MTIME_HI_ADDR:    mtime_nxt    = merge_bytes(mtime, wr_hi_data, wr_hi_strb);
        MTIMECMP_ADDR:    mtimecmp_nxt = merge_bytes(mtimecmp, s.wdata, s.wstrb);
        MTIMECMP_HI_ADDR: mtimecmp_nxt = merge_bytes(mtimecmp, wr_hi_data, wr_hi_strb);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mtime     <= '0;
      mtimecmp  <= '1;
      timer_irq <= 1'b0;
      r_pend    <= 1'b0;
      b_pend    <= 1'b0;
    end else begin
      mtime     <= mtime_nxt;
      mtimecmp  <= mtimecmp_nxt;
      timer_irq <= mtime >= mtimecmp;
      r_pend    <= rd_en || (r_pend && !s.rready);
      b_pend    <= wr_en || (b_pend && !s.bready);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata_q <= rd_word;
    end
  end

endmodule

/* hdl/soc_periph_top.sv */
module soc_periph_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           arvalid,
  output logic                           arready,
  input  logic [soc_bus_pkg::ADDR_W-1:0] araddr,
  output logic                           rvalid,
  input  logic                           rready,
  output logic [soc_bus_pkg::DATA_W-1:0] rdata,
  output soc_bus_pkg::resp_e             rresp,
  input  logic                           awvalid,
  output logic                           awready,
  input  logic [soc_bus_pkg::ADDR_W-1:0] awaddr,
  input  logic                           wvalid,
  output logic                           wready,
  input  logic [soc_bus_pkg::DATA_W-1:0] wdata,
  input  logic [soc_bus_pkg::STRB_W-1:0] wstrb,
  output logic                           bvalid,
  input  logic                           bready,
  output soc_bus_pkg::resp_e             bresp,
  output logic                           device_access,
  output logic                           timer_irq
);

  axi_lite_if m_bus ();
  axi_lite_if sram_bus ();
  axi_lite_if clint_bus ();

  // master side onto the bundle
  assign m_bus.arvalid = arvalid;
  assign m_bus.araddr  = araddr;
  assign m_bus.rready  = rready;
  assign m_bus.awvalid = awvalid;
  assign m_bus.awaddr  = awaddr;
  assign m_bus.wvalid  = wvalid;
  assign m_bus.wdata   = wdata;
  assign m_bus.wstrb   = wstrb;
  assign m_bus.bready  = bready;

  assign arready = m_bus.arready;
  assign rvalid  = m_bus.rvalid;
  assign rdata   = m_bus.rdata;
  assign rresp   = m_bus.rresp;
  assign awready = m_bus.awready;
  assign wready  = m_bus.wready;
  assign bvalid  = m_bus.bvalid;
  assign bresp   = m_bus.bresp;

  soc_xbar xbar0 (
    .clk           (clk),
    .rst           (rst),
    .m             (m_bus.slave),
    .sram_bus      (sram_bus.master),
    .clint_bus     (clint_bus.master),
    .device_access (device_access)
  );

  sram_slave sram0 (
    .clk (clk),
    .rst (rst),
    .s   (sram_bus.slave)
  );

  clint_timer clint0 (
    .clk       (clk),
    .rst       (rst),
    .s         (clint_bus.slave),
    .timer_irq (timer_irq)
  );

endmodule

/* tests/clk_gen.sv */
module clk_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst <= 1'b0;
  end

endmodule

/* tests/soc_xbar_assert.sv */
module soc_xbar_assert (
  input logic                           clk,
  input logic                           rst,
  input logic                           arvalid,
  input logic                           arready,
  input logic [soc_bus_pkg::ADDR_W-1:0] araddr,
  input logic                           rvalid,
  input logic                           rready,
  input logic                           awvalid,
  input logic                           awready,
  input logic                           bvalid,
  input logic                           bready,
  input logic                           device_access
);
  timeunit 1ns;
  timeprecision 1ps;
  import soc_bus_pkg::*;

  logic ar_in_sram;

  assign ar_in_sram = araddr >= SRAM_BASE && araddr < SRAM_BASE + SRAM_SIZE;

  // ##########################################################################
  // valid held until ready
  // ##########################################################################

  ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
    else $error("arvalid dropped before arready");
  aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
    else $error("awvalid dropped before awready");
  r_hold: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");
  b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // response one cycle after the request transfer
  r_lat: assert property (@(posedge clk) disable iff (rst) arvalid && arready |=> rvalid)
    else $error("read response late");
  b_lat: assert property (@(posedge clk) disable iff (rst) awvalid && awready |=> bvalid)
    else $error("write response late");

  sram_quiet: assert property (@(posedge clk) disable iff (rst)
      arvalid && ar_in_sram && !awvalid |-> !device_access)
    else $error("device_access high for an sram address");

endmodule

bind soc_xbar soc_xbar_assert xbar_chk (
  .clk           (clk),
  .rst           (rst),
  .arvalid       (m.arvalid),
  .arready       (m.arready),
  .araddr        (m.araddr),
  .rvalid        (m.rvalid),
  .rready        (m.rready),
  .awvalid       (m.awvalid),
  .awready       (m.awready),
  .bvalid        (m.bvalid),
  .bready        (m.bready),
  .device_access (device_access)
);

/* tests/soc_periph_tb.sv */
module soc_periph_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import soc_bus_pkg::*;

  localparam int N_TXN       = 120;
  localparam int TXN_BOUND   = 40;                  // cycles per transaction including the longest hold
  localparam int CYCLE_LIMIT = N_TXN * TXN_BOUND;

  logic clk, rst;
  logic arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready;
  logic bvalid, bready, device_access, timer_irq;
  logic [ADDR_W-1:0] araddr, awaddr;
  logic [DATA_W-1:0] rdata, wdata;
  logic [STRB_W-1:0] wstrb;
  resp_e rresp, bresp;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  logic [31:0] lfsr = 32'hba91;
  logic [DATA_W-1:0] model [8];       // expected contents of the sram pool
  logic [ADDR_W-1:0] pool [8];

  clk_gen clk_gen0 (.clk(clk), .rst(rst));
  soc_periph_top dut0 (.*);

  // ##########################################################################
  // random numbers and reference model
  // ##########################################################################

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);         // one step per bit
      v = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic zone_e ref_zone(input logic [ADDR_W-1:0] a);
    if (a >= SRAM_BASE && a - SRAM_BASE < SRAM_WORDS * 8) return ZONE_SRAM;
    if (a == MTIME_ADDR || a == MTIME_HI_ADDR) return ZONE_CLINT;
    if (a == MTIMECMP_ADDR || a == MTIMECMP_HI_ADDR) return ZONE_CLINT;
    return ZONE_NONE;
  endfunction

  function automatic logic [DATA_W-1:0] ref_merge(input logic [DATA_W-1:0] old_w,
      input logic [DATA_W-1:0] new_w, input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] mask;
    for (int i = 0; i < STRB_W; i++) mask[i*8 +: 8] = {8{strb[i]}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  // ##########################################################################
  // compare tasks
  // ##########################################################################

  task automatic check_resp(input resp_e got, input resp_e exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s resp %s expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s data %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b expected %b", $time, what, got, exp);
    end
  endtask

  // ##########################################################################
  // bus tasks that start and end just after a falling edge
  // ##########################################################################

  // with hold > 0 a second read to next_addr is left pending for the caller
  task automatic read_txn(input logic [ADDR_W-1:0] addr, input int hold,
                          input logic [ADDR_W-1:0] next_addr,
                          output logic [DATA_W-1:0] data, output resp_e resp);
    logic [DATA_W-1:0] first;
    arvalid = 1'b1;
    araddr  = addr;
    rready  = (hold == 0);
    #1;
    check_flag(device_access, ref_zone(addr) != ZONE_SRAM, "device_access on read");
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = (hold > 0);
    araddr  = next_addr;
    #1;
    while (!rvalid) begin
      @(negedge clk);
      #1;
    end
    first = rdata;
    repeat (hold) begin
      @(negedge clk);
      #1;
      check_flag(rvalid, 1'b1, "rvalid under back-pressure");
      check_data(rdata, first, "rdata under back-pressure");
      check_flag(arready, 1'b0, "second read accepted");
    end
    if (hold > 0) begin
      @(negedge clk);
      rready = 1'b1;
      #1;
    end
    data = rdata;
    resp = rresp;
    @(negedge clk);
  endtask

  task automatic write_txn(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, input int hold, output resp_e resp);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    bready  = (hold == 0);
    #1;
    check_flag(device_access, ref_zone(addr) != ZONE_SRAM, "device_access on write");
    while (!awready) begin
      @(negedge clk);
      #1;
    end
    check_flag(wready, 1'b1, "wready with awready");
    @(negedge clk);
    awvalid = (hold > 0);   // the same write waits behind a held response
    wvalid  = (hold > 0);
    #1;
    while (!bvalid) begin
      @(negedge clk);
      #1;
    end
    repeat (hold) begin
      @(negedge clk);
      #1;
      check_flag(bvalid, 1'b1, "bvalid under back-pressure");
      check_flag(awready, 1'b0, "awready while response held");
    end
    if (hold > 0) begin
      @(negedge clk);
      bready = 1'b1;
      #1;
    end
    resp = bresp;
    @(negedge clk);
    if (hold > 0) begin
      #1;
      while (!awready) begin
        @(negedge clk);
        #1;
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      #1;
      while (!bvalid) begin
        @(negedge clk);
        #1;
      end
      check_resp(bresp, (ref_zone(addr) == ZONE_NONE) ? RESP_DECERR : RESP_OKAY,
                 "repeated write");
      @(negedge clk);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %-14s %s", name, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  // ##########################################################################
  // run limit
  // ##########################################################################

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    int e0;
    int slot;
    logic [63:0] r64;
    logic [DATA_W-1:0] d, v, t1, t2;
    logic [ADDR_W-1:0] a;
    resp_e rs;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    @(negedge clk);
    while (rst) @(negedge clk);

    // sram with random strobes over a pool of eight distinct words
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      r64 = rand_bits(6);
      pool[i] = SRAM_BASE + {r64[5:0], i[2:0], 3'b000};
      model[i] = rand_bits(64);
      write_txn(pool[i], model[i], 8'hff, 0, rs);
      check_resp(rs, RESP_OKAY, "sram init write");
    end
    for (int i = 0; i < 24; i++) begin
      r64 = rand_bits(3);
      slot = r64[2:0];
      d = rand_bits(64);
      r64 = rand_bits(8);
      write_txn(pool[slot], d, r64[7:0], 0, rs);
      model[slot] = ref_merge(model[slot], d, r64[7:0]);
      check_resp(rs, RESP_OKAY, "sram write");
    end
    for (int i = 0; i < 8; i++) begin
      read_txn(pool[i], 0, '0, d, rs);
      check_resp(rs, RESP_OKAY, "sram read");
      check_data(d, model[i], "sram read");
    end
    report_test("sram", e0);

    // unmapped
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      r64 = rand_bits(20);
      a = 32'h1000_0000 | {12'h0, r64[19:0]};
      read_txn(a, 0, '0, d, rs);
      check_resp(rs, (ref_zone(a) == ZONE_NONE) ? RESP_DECERR : RESP_OKAY, "unmapped read");
      check_data(d, '0, "unmapped read");
      write_txn(a, rand_bits(64), 8'hff, 0, rs);
      check_resp(rs, RESP_DECERR, "unmapped write");
    end
    read_txn(pool[0], 0, '0, d, rs);
    check_data(d, model[0], "sram after decerr");
    report_test("unmapped", e0);

    // mtimecmp full and upper half followed by the interrupt
    e0 = errors;
    v = rand_bits(64);
    write_txn(MTIMECMP_ADDR, v, 8'hff, 0, rs);
    read_txn(MTIMECMP_ADDR, 0, '0, d, rs);
    check_data(d, v, "mtimecmp full");
    r64 = rand_bits(32);
    write_txn(MTIMECMP_HI_ADDR, {32'h0, r64[31:0]}, 8'h0f, 0, rs);
    v = {r64[31:0], v[31:0]};
    read_txn(MTIMECMP_ADDR, 0, '0, d, rs);
    check_data(d, v, "mtimecmp after hi write");
    read_txn(MTIMECMP_HI_ADDR, 0, '0, d, rs);
    check_resp(rs, RESP_OKAY, "mtimecmp hi read");
    check_data(d, {32'h0, v[63:32]}, "mtimecmp hi");
    write_txn(MTIMECMP_ADDR, '0, 8'hff, 0, rs);
    repeat (4) if (!timer_irq) @(negedge clk);
    check_flag(timer_irq, 1'b1, "timer_irq");
    report_test("mtimecmp", e0);

    // mtime
    e0 = errors;
    read_txn(MTIME_ADDR, 0, '0, t1, rs);
    read_txn(MTIME_ADDR, 0, '0, t2, rs);
    check_flag(t2 >= t1, 1'b1, "mtime nondecreasing");
    v = rand_bits(64) >> 1;
    write_txn(MTIME_ADDR, v, 8'hff, 0, rs);
    read_txn(MTIME_ADDR, 0, '0, d, rs);
    check_flag(d >= v && d < v + TXN_BOUND, 1'b1, "mtime after write");
    report_test("mtime", e0);

    // back-pressure and a changed araddr behind a pending clint read
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      r64 = rand_bits(4);
      d = rand_bits(64);
      write_txn(pool[i], d, 8'hff, r64[3:0] + 1, rs);
      model[i] = d;
      check_resp(rs, RESP_OKAY, "held write");
      read_txn(pool[i], r64[3:0] + 1, pool[i+4], d, rs);
      check_data(d, model[i], "held sram read");
      read_txn(pool[i+4], 0, '0, d, rs);
      check_data(d, model[i+4], "read queued behind held read");
    end
    read_txn(MTIMECMP_ADDR, 5, pool[1], d, rs);
    check_data(d, '0, "clint read with changed araddr");
    read_txn(pool[1], 0, '0, d, rs);
    check_data(d, model[1], "sram read after clint");
    report_test("backpressure", e0);

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* soc_periph_top.f */
hdl/soc_bus_pkg.sv
hdl/axi_lite_if.sv
hdl/soc_xbar.sv
hdl/sram_slave.sv
hdl/clint_timer.sv
hdl/soc_periph_top.sv
tests/clk_gen.sv
tests/soc_xbar_assert.sv
tests/soc_periph_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module soc_periph_tb -f soc_periph_top.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vsoc_periph_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "All tests passed" "$LOG"; then
  exit 0
fi
exit 1
